//--- field_digit_counter.sv
`timescale 1ns/100ps

module field_digit_counter (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    clear_count,
    input  logic                                    count_digit,
    output logic [trace_char_pkg::DIGIT_COUNT_W-1:0] digit_count
);

    logic at_max;

    assign at_max = &digit_count;

    // Holds at the top so an over-long field keeps failing
    always_ff @(posedge clk) begin
        if (reset || clear_count) begin
            digit_count <= '0;
        end else if (count_digit && !at_max) begin
            digit_count <= digit_count + 1'b1;
        end
    end

    a_count_monotonic: assert property (@(posedge clk) disable iff (reset)
        !clear_count |=> digit_count >= $past(digit_count));

endmodule

//--- field_rule_checker.sv
`timescale 1ns/100ps

module field_rule_checker (
    input  logic                         line_done,
    input  trace_check_pkg::format_t     line_format,
    input  logic [15:0]                  freq,
    input  trace_check_pkg::time_field_t time_digits,
    input  trace_check_pkg::word_field_t pc_value,
    input  trace_check_pkg::word_field_t operand_value,
    output trace_check_pkg::format_t     format_type,
    output logic [3:0]                   error_code
);

    logic [15:0] time_bin;
    logic [15:0] reg_bin;
    logic [15:0] time_mask;
    logic [3:0]  rule_errors;

    function automatic logic [15:0] bcd4_to_bin(input logic [15:0] bcd);
        bcd4_to_bin = bcd[15:12] * 16'd1000 + bcd[11:8] * 16'd100
                    + bcd[7:4] * 16'd10 + bcd[3:0];
    endfunction

    //////////////////////////////////////////////////
    // Rule evaluation

    assign time_bin = bcd4_to_bin(time_digits);
    assign reg_bin  = bcd4_to_bin(operand_value[15:0]);

    // freq is a power of two, so freq/2 - 1 masks the remainder
    assign time_mask = (freq >> 1) - 16'd1;

    always_comb begin
        rule_errors = '0;
        rule_errors[trace_check_pkg::ERR_TIME] = (time_bin & time_mask) != 16'd0;
        rule_errors[trace_check_pkg::ERR_PC] =
            (pc_value < trace_check_pkg::PC_LOW) ||
            (pc_value > trace_check_pkg::PC_HIGH) ||
            (pc_value[1:0] != 2'b00);
        if (line_format == trace_check_pkg::FORMAT_MEM) begin
            rule_errors[trace_check_pkg::ERR_ADDR] =
                (operand_value > trace_check_pkg::ADDR_HIGH) ||
                (operand_value[1:0] != 2'b00);
        end
        if (line_format == trace_check_pkg::FORMAT_REG) begin
            rule_errors[trace_check_pkg::ERR_REG] = reg_bin > trace_check_pkg::REG_HIGH;
        end
    end

    // Result only in the done cycle
    assign format_type = line_done ? line_format : trace_check_pkg::FORMAT_NONE;
    assign error_code  = line_done ? rule_errors : 4'd0;

    // A finished line always has a latched format
    always_comb begin
        a_done_format: assert #0 (!line_done ||
            line_format inside {trace_check_pkg::FORMAT_REG, trace_check_pkg::FORMAT_MEM});
    end

endmodule

//--- field_shift_reg.sv
`timescale 1ns/100ps

module field_shift_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       clear_fields,
    input  logic       shift,
    input  logic [3:0] nibble,
    output payload_t   value
);

    localparam int WIDTH = $bits(payload_t);

    logic [WIDTH-1:0] shifted;

    // Oldest digit drops off the top
    assign shifted = {value[WIDTH-5:0], nibble};

    always_ff @(posedge clk) begin
        if (reset || clear_fields) begin
            value <= '0;
        end else if (shift) begin
            value <= payload_t'(shifted);
        end
    end

endmodule

//--- line_parser_fsm.sv
`timescale 1ns/100ps

module line_parser_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [7:0]               char,
    input  logic [3:0]               digit_count,
    output logic [3:0]               nibble,
    output logic                     shift_time,
    output logic                     shift_pc,
    output logic                     shift_operand,
    output logic                     clear_fields,
    output logic                     count_digit,
    output logic                     clear_count,
    output logic                     line_done,
    output trace_check_pkg::format_t line_format
);

    trace_char_pkg::parse_state_t state;
    trace_char_pkg::parse_state_t next_state;
    trace_char_pkg::parse_state_t fail_state;

    logic is_dec;
    logic is_hex;
    logic in_field;
    logic start_line;
    logic reg_line;
    logic operand_digit;
    logic operand_len_ok;
    logic field_digit;

    //////////////////////////////////////////////////
    // Character classes

    assign is_dec = (char >= "0") && (char <= "9");
    assign is_hex = is_dec || ((char >= "a") && (char <= "f"));
    // 'a' has low nibble 1
    assign nibble = is_dec ? char[3:0] : char[3:0] + 4'd9;

    assign in_field = state inside {trace_char_pkg::ST_TIME, trace_char_pkg::ST_PC,
                                    trace_char_pkg::ST_OPERAND, trace_char_pkg::ST_DATA};
    assign start_line = (char == trace_char_pkg::CH_CARET) && !in_field;
    assign fail_state = (char == trace_char_pkg::CH_HASH) ? trace_char_pkg::ST_ERROR_DONE
                                                          : trace_char_pkg::ST_ERROR;

    assign reg_line      = line_format == trace_check_pkg::FORMAT_REG;
    assign operand_digit = reg_line ? is_dec : is_hex;
    assign operand_len_ok = reg_line ?
        (digit_count >= 1 && digit_count <= trace_char_pkg::REG_MAX_DIGITS) :
        (digit_count == trace_char_pkg::ADDR_DIGITS);

    //////////////////////////////////////////////////
    // Line grammar

    always_comb begin
        next_state  = fail_state;
        field_digit = 1'b0;
        if (start_line) begin
            next_state = trace_char_pkg::ST_START;
        end else begin
            case (state)
                trace_char_pkg::ST_IDLE: next_state = trace_char_pkg::ST_IDLE;
                trace_char_pkg::ST_START, trace_char_pkg::ST_TIME: begin
                    if (is_dec) begin
                        next_state  = trace_char_pkg::ST_TIME;
                        field_digit = 1'b1;
                    end else if (state == trace_char_pkg::ST_TIME &&
                                 char == trace_char_pkg::CH_AT) begin
                        // Count is at least one here
                        next_state = (digit_count <= trace_char_pkg::TIME_MAX_DIGITS) ?
                                     trace_char_pkg::ST_AT : trace_char_pkg::ST_ERROR;
                    end
                end
                trace_char_pkg::ST_AT, trace_char_pkg::ST_PC: begin
                    if (is_hex) begin
                        next_state  = trace_char_pkg::ST_PC;
                        field_digit = 1'b1;
                    end else if (state == trace_char_pkg::ST_PC &&
                                 char == trace_char_pkg::CH_COLON) begin
                        next_state = (digit_count == trace_char_pkg::PC_DIGITS) ?
                                     trace_char_pkg::ST_COLON : trace_char_pkg::ST_ERROR;
                    end
                end
                trace_char_pkg::ST_COLON: begin
                    if (char == trace_char_pkg::CH_SPACE) begin
                        next_state = trace_char_pkg::ST_COLON;
                    end else if (char == trace_char_pkg::CH_DOLLAR ||
                                 char == trace_char_pkg::CH_STAR) begin
                        next_state = trace_char_pkg::ST_SIGN;
                    end
                end
                trace_char_pkg::ST_SIGN, trace_char_pkg::ST_OPERAND: begin
                    if (operand_digit) begin
                        next_state  = trace_char_pkg::ST_OPERAND;
                        field_digit = 1'b1;
                    end else if (state == trace_char_pkg::ST_OPERAND &&
                                 char == trace_char_pkg::CH_SPACE) begin
                        next_state = operand_len_ok ? trace_char_pkg::ST_SPACE
                                                    : trace_char_pkg::ST_ERROR;
                    end else if (state == trace_char_pkg::ST_OPERAND &&
                                 char == trace_char_pkg::CH_LESS) begin
                        next_state = operand_len_ok ? trace_char_pkg::ST_LESS
                                                    : trace_char_pkg::ST_ERROR;
                    end
                end
                trace_char_pkg::ST_SPACE: begin
                    if (char == trace_char_pkg::CH_SPACE) begin
                        next_state = trace_char_pkg::ST_SPACE;
                    end else if (char == trace_char_pkg::CH_LESS) begin
                        next_state = trace_char_pkg::ST_LESS;
                    end
                end
                trace_char_pkg::ST_LESS: begin
                    if (char == trace_char_pkg::CH_EQUAL) begin
                        next_state = trace_char_pkg::ST_EQUAL;
                    end
                end
                trace_char_pkg::ST_EQUAL, trace_char_pkg::ST_DATA: begin
                    if (is_hex) begin
                        next_state  = trace_char_pkg::ST_DATA;
                        field_digit = 1'b1;
                    end else if (state == trace_char_pkg::ST_EQUAL &&
                                 char == trace_char_pkg::CH_SPACE) begin
                        next_state = trace_char_pkg::ST_EQUAL;
                    end else if (state == trace_char_pkg::ST_DATA &&
                                 char == trace_char_pkg::CH_HASH) begin
                        next_state = (digit_count == trace_char_pkg::DATA_DIGITS) ?
                                     trace_char_pkg::ST_DONE : trace_char_pkg::ST_ERROR_DONE;
                    end else if (state == trace_char_pkg::ST_DATA) begin
                        next_state = trace_char_pkg::ST_ERROR;
                    end
                end
                trace_char_pkg::ST_DONE, trace_char_pkg::ST_ERROR_DONE: begin
                    next_state = trace_char_pkg::ST_IDLE;
                end
                // Error waits for '#' or '^'
                default: next_state = fail_state;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= trace_char_pkg::ST_IDLE;
            line_format <= trace_check_pkg::FORMAT_NONE;
        end else begin
            state <= next_state;
            if (state == trace_char_pkg::ST_COLON && char == trace_char_pkg::CH_DOLLAR) begin
                line_format <= trace_check_pkg::FORMAT_REG;
            end else if (state == trace_char_pkg::ST_COLON &&
                         char == trace_char_pkg::CH_STAR) begin
                line_format <= trace_check_pkg::FORMAT_MEM;
            end
        end
    end

    //////////////////////////////////////////////////
    // Field register and counter control

    assign shift_time    = field_digit && next_state == trace_char_pkg::ST_TIME;
    assign shift_pc      = field_digit && next_state == trace_char_pkg::ST_PC;
    assign shift_operand = field_digit && next_state == trace_char_pkg::ST_OPERAND;
    assign count_digit   = field_digit;
    // Count restarts on every non-digit so each field is measured alone
    assign clear_count   = !field_digit;
    assign clear_fields  = start_line;
    assign line_done     = state == trace_char_pkg::ST_DONE;

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) &&
        state inside {[trace_char_pkg::ST_IDLE:trace_char_pkg::ST_ERROR_DONE]});

    // A new line needs at least a '^' and the whole body
    a_done_single: assert property (@(posedge clk) disable iff (reset)
        line_done |=> !line_done);

    a_shift_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({shift_time, shift_pc, shift_operand}));

endmodule

//--- tb_trace_checker.sv
`timescale 1ns/100ps

module tb_trace_checker;

    typedef enum int {PH_WAIT, PH_TIME, PH_PC, PH_SIGN, PH_OPER, PH_SPACE, PH_LESS, PH_DATA}
        ref_phase_t;

    logic                     clk;
    logic                     reset;
    logic [7:0]               char;
    logic [15:0]              freq;
    trace_check_pkg::format_t format_type;
    logic [3:0]               error_code;

    int seed = 37557;
    int cyc = 0;
    int error_count = 0;
    int limit_cycles = 0;

    // Test schedule
    string       item_q[$];
    logic [15:0] freq_q[$];
    bit          reset_q[$];

    // Expected results keyed by cycle
    logic [1:0] exp_fmt[int];
    logic [3:0] exp_code[int];

    // Reference parser state survives between strings until a reset
    ref_phase_t  ref_phase = PH_WAIT;
    int          ref_count = 0;
    bit          ref_is_reg = 1'b0;
    logic [31:0] ref_time = '0;
    logic [31:0] ref_pc = '0;
    logic [31:0] ref_oper = '0;

    trace_checker u_dut (
        .clk         (clk),
        .reset       (reset),
        .char        (char),
        .freq        (freq),
        .format_type (format_type),
        .error_code  (error_code)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    //////////////////////////////////////////////////
    // Reference model

    function automatic void predict_results(input string s, input int base,
                                            input logic [15:0] f);
        logic [7:0] ch;
        logic [3:0] val;
        logic [3:0] code;
        bit         dec;
        bit         hex;
        bit         len_ok;
        ref_phase_t prev;
        for (int i = 0; i < s.len(); i++) begin
            ch   = s[i];
            dec  = (ch >= "0") && (ch <= "9");
            hex  = dec || ((ch >= "a") && (ch <= "f"));
            val  = dec ? 4'(ch - "0") : 4'(ch - "a" + 10);
            prev = ref_phase;
            if (ch == "^" && !(ref_count > 0 &&
                    ref_phase inside {PH_TIME, PH_PC, PH_OPER, PH_DATA})) begin
                ref_phase = PH_TIME;
                ref_time  = '0;
                ref_pc    = '0;
                ref_oper  = '0;
            end else begin
                case (ref_phase)
                    PH_TIME: begin
                        if (dec) begin
                            ref_time = ref_time * 10 + val;
                            ref_count++;
                        end else begin
                            ref_phase = (ch == "@" && ref_count >= 1 && ref_count <= 4) ?
                                        PH_PC : PH_WAIT;
                        end
                    end
                    PH_PC: begin
                        if (hex) begin
                            ref_pc = {ref_pc[27:0], val};
                            ref_count++;
                        end else begin
                            ref_phase = (ch == ":" && ref_count == 8) ? PH_SIGN : PH_WAIT;
                        end
                    end
                    PH_SIGN: begin
                        if (ch == "$" || ch == "*") begin
                            ref_is_reg = (ch == "$");
                            ref_phase  = PH_OPER;
                        end else if (ch != " ") begin
                            ref_phase = PH_WAIT;
                        end
                    end
                    PH_OPER: begin
                        len_ok = ref_is_reg ? (ref_count >= 1 && ref_count <= 4)
                                            : (ref_count == 8);
                        if (ref_is_reg ? dec : hex) begin
                            ref_oper = ref_is_reg ? ref_oper * 10 + val : {ref_oper[27:0], val};
                            ref_count++;
                        end else if (len_ok && ch == " ") begin
                            ref_phase = PH_SPACE;
                        end else if (len_ok && ch == "<") begin
                            ref_phase = PH_LESS;
                        end else begin
                            ref_phase = PH_WAIT;
                        end
                    end
                    PH_SPACE: begin
                        if (ch == "<") begin
                            ref_phase = PH_LESS;
                        end else if (ch != " ") begin
                            ref_phase = PH_WAIT;
                        end
                    end
                    PH_LESS: ref_phase = (ch == "=") ? PH_DATA : PH_WAIT;
                    PH_DATA: begin
                        if (hex) begin
                            ref_count++;
                        end else if (!(ch == " " && ref_count == 0)) begin
                            if (ch == "#" && ref_count == 8) begin
                                code = '0;
                                code[trace_check_pkg::ERR_TIME] = (ref_time % (f / 2)) != 0;
                                code[trace_check_pkg::ERR_PC] =
                                    ref_pc < trace_check_pkg::PC_LOW ||
                                    ref_pc > trace_check_pkg::PC_HIGH || ref_pc % 4 != 0;
                                if (ref_is_reg) begin
                                    code[trace_check_pkg::ERR_REG] =
                                        ref_oper > trace_check_pkg::REG_HIGH;
                                end else begin
                                    code[trace_check_pkg::ERR_ADDR] =
                                        ref_oper > trace_check_pkg::ADDR_HIGH ||
                                        ref_oper % 4 != 0;
                                end
                                exp_fmt[base + i + 1]  = ref_is_reg ? trace_check_pkg::FORMAT_REG
                                                                    : trace_check_pkg::FORMAT_MEM;
                                exp_code[base + i + 1] = code;
                            end
                            ref_phase = PH_WAIT;
                        end
                    end
                    default: ref_phase = PH_WAIT;
                endcase
            end
            // Each field is measured from its first digit
            if (ref_phase != prev || ch == "^") begin
                ref_count = 0;
            end
        end
    endfunction

    //////////////////////////////////////////////////
    // Stimulus helpers

    function automatic int pick(input int n);
        pick = $unsigned($random(seed)) % n;
    endfunction

    function automatic string spaces(input int n);
        string s;
        s = "";
        repeat (n) s = {s, " "};
        return s;
    endfunction

    function automatic string random_line();
        string       s;
        string       corrupt;
        logic [31:0] pc;
        logic [31:0] addr;
        int          ndig;
        corrupt = "A:$ #g1^";
        s = "";
        if (pick(3) == 0) s = "x#";
        s = {s, "^"};
        ndig = (pick(8) == 0) ? 5 : 1 + pick(4);
        repeat (ndig) s = $sformatf("%s%0d", s, pick(10));
        pc = 32'h2800 + pick(32'h3000);
        if (pick(3) != 0) pc[1:0] = 2'b00;
        s = $sformatf("%s@%08h:%s", s, pc, spaces(pick(3)));
        if (pick(2) == 0) begin
            s = $sformatf("%s$%0d", s, pick(40));
        end else begin
            addr = pick(32'h3800);
            if (pick(3) != 0) addr[1:0] = 2'b00;
            s = $sformatf("%s*%08h", s, addr);
        end
        s = $sformatf("%s%s<=%s%08h#", s, spaces(pick(3)), spaces(pick(3)), $random(seed));
        if (pick(6) == 0) s.putc(pick(s.len()), corrupt[pick(8)]);
        return s;
    endfunction

    function automatic void add_item(input string s, input logic [15:0] f, input bit rst);
        item_q.push_back(s);
        freq_q.push_back(f);
        reset_q.push_back(rst);
    endfunction

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        #2;
        reset = 1'b1;
        char  = 8'h00;
        repeat (cycles) @(posedge clk);
        #2;
        reset = 1'b0;
        ref_phase = PH_WAIT;
        ref_count = 0;
    endtask

    // Leading filler keeps the old freq until the previous result is compared
    task automatic send_string(input string line, input logic [15:0] f);
        string s;
        s = {" ", line};
        @(posedge clk);
        #2;
        predict_results(s, cyc, f);
        for (int i = 0; i < s.len(); i++) begin
            if (i > 0) begin
                @(posedge clk);
                #2;
                freq = f;
            end
            char = s[i];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("error: %s expected %h got %h at cycle %0d", name, expected, actual, cyc);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    //////////////////////////////////////////////////
    // Checking and watchdog

    initial begin
        forever begin
            @(posedge clk);
            #5;
            check_value("format_type", exp_fmt.exists(cyc) ? exp_fmt[cyc] : 2'd0, format_type);
            check_value("error_code", exp_code.exists(cyc) ? exp_code[cyc] : 4'd0, error_code);
        end
    end

    initial begin
        wait (limit_cycles > 0);
        #((limit_cycles + 200) * 40);
        $display("timeout: the test sequence did not finish within %0d cycles", limit_cycles);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset = 1'b1;
        char  = 8'h00;
        freq  = 16'd8;

        add_item("^100@00003000:$5<=0000abcd#", 16'd8, 0);
        add_item("^16@00004ffc:  *00002ffc  <=  12345678#", 16'd8, 0);
        add_item("^8@00003ffc: $0 <= ffffffff#..", 16'd16, 0);
        // Time rule under several freq values
        add_item("^6@00003000:$1<=00000000#", 16'd4, 0);
        add_item("^6@00003000:$1<=00000000#", 16'd8, 0);
        add_item("^6@00003000:$1<=00000000#", 16'd2, 0);
        add_item("^9990@00003000:$1<=00000000#", 16'd64, 0);
        add_item("^0@00002ffc:$1<=00000000#^0@00005000:$1<=00000000#", 16'd8, 0);
        add_item("^0@00004000:$1<=00000000#zz^0@00003002:$1<=00000000#", 16'd8, 0);
        add_item("^0@00003000:*00003000<=00000000#^0@00003000:*00000001<=00000000#", 16'd8, 0);
        add_item("^0@00003000:$32<=00000000# ^0@00003000:$0031<=00000000#", 16'd8, 0);
        add_item("^7@00005001:$32<=00000000#^7@00002ffd:*00003001<=00000000#", 16'd4, 0);
        // Malformed lines
        add_item("^@00003000:$1<=00000000#^12345@00003000:$1<=00000000#", 16'd8, 0);
        add_item("^1@0000300:$1<=00000000#^1@000030000:$1<=00000000#", 16'd8, 0);
        add_item("^1@00003000 $1<=00000000#^1@00003000:$1<00000000#", 16'd8, 0);
        add_item("^1@00003000:$1<=0000000#^1@00003000:$1<=000000000#", 16'd8, 0);
        add_item("^1@0000300A:$1<=00000000#^1@00003000:$1<=0000g000#", 16'd8, 0);
        add_item("^1@00003000:$00031<=00000000#^12@0000^16@00003000:$3<=00000000#", 16'd8, 0);
        // Sequencing and recovery
        add_item("^4@00003000:$2<=00000001#^1@0000300:$1<=0#^8@00003000:*00000010<=abcdef01#",
                 16'd8, 0);
        add_item("^1@00003000:$1<=0000zz^4@00003000:$9<=00000000#", 16'd8, 0);
        add_item("^12@000030", 16'd8, 0);
        add_item("00:$1<=00000000#^8@00003000:$3<=00000000#", 16'd8, 1);
        repeat (200) add_item(random_line(), 16'd2 << pick(6), 0);

        limit_cycles = 16 + 4;
        foreach (item_q[i]) begin
            limit_cycles += item_q[i].len() + 1 + (reset_q[i] ? 17 : 0);
        end

        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (item_q[i]) begin
            if (reset_q[i]) apply_reset(16);
            send_string(item_q[i], freq_q[i]);
        end
        @(posedge clk);
        #2;
        char = 8'h00;
        repeat (3) @(posedge clk);
        #10;
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- trace_char_pkg.sv
package trace_char_pkg;

    //////////////////////////////////////////////////
    // Parser states

    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_START      = 4'd1,
        ST_TIME       = 4'd2,
        ST_AT         = 4'd3,
        ST_PC         = 4'd4,
        ST_COLON      = 4'd5,
        ST_SIGN       = 4'd6,
        ST_OPERAND    = 4'd7,
        ST_SPACE      = 4'd8,
        ST_LESS       = 4'd9,
        ST_EQUAL      = 4'd10,
        ST_DATA       = 4'd11,
        ST_DONE       = 4'd12,
        ST_ERROR      = 4'd13,
        ST_ERROR_DONE = 4'd14
    } parse_state_t;

    //////////////////////////////////////////////////
    // Separator characters

    localparam logic [7:0] CH_CARET  = 8'h5e;
    localparam logic [7:0] CH_AT     = 8'h40;
    localparam logic [7:0] CH_COLON  = 8'h3a;
    localparam logic [7:0] CH_DOLLAR = 8'h24;
    localparam logic [7:0] CH_STAR   = 8'h2a;
    localparam logic [7:0] CH_SPACE  = 8'h20;
    localparam logic [7:0] CH_LESS   = 8'h3c;
    localparam logic [7:0] CH_EQUAL  = 8'h3d;
    localparam logic [7:0] CH_HASH   = 8'h23;

    // Field lengths in digits
    localparam int TIME_MAX_DIGITS = 4;
    localparam int PC_DIGITS       = 8;
    localparam int ADDR_DIGITS     = 8;
    localparam int REG_MAX_DIGITS  = 4;
    localparam int DATA_DIGITS     = 8;

    localparam int DIGIT_COUNT_W = 4;

endpackage

//--- trace_check_pkg.sv
package trace_check_pkg;

    //////////////////////////////////////////////////
    // Line format and error bits

    typedef enum logic [1:0] {
        FORMAT_NONE = 2'd0,
        FORMAT_REG  = 2'd1,
        FORMAT_MEM  = 2'd2
    } format_t;

    localparam int ERR_TIME = 0;
    localparam int ERR_PC   = 1;
    localparam int ERR_ADDR = 2;
    localparam int ERR_REG  = 3;

    //////////////////////////////////////////////////
    // Legal ranges

    // Instruction memory window
    localparam logic [31:0] PC_LOW  = 32'h0000_3000;
    localparam logic [31:0] PC_HIGH = 32'h0000_4fff;

    // Data memory ends below the code
    localparam logic [31:0] ADDR_HIGH = 32'h0000_2fff;

    localparam logic [15:0] REG_HIGH = 16'd31;

    // Four BCD digits of time, eight nibbles of pc or operand
    typedef logic [15:0] time_field_t;
    typedef logic [31:0] word_field_t;

endpackage

//--- trace_checker.f
trace_char_pkg.sv
trace_check_pkg.sv
line_parser_fsm.sv
field_digit_counter.sv
field_shift_reg.sv
field_rule_checker.sv
trace_checker.sv
tb_trace_checker.sv

//--- trace_checker.sv
`timescale 1ns/100ps

module trace_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [7:0]               char,
    input  logic [15:0]              freq,
    output trace_check_pkg::format_t format_type,
    output logic [3:0]               error_code
);

    logic [3:0] nibble;
    logic       shift_time;
    logic       shift_pc;
    logic       shift_operand;
    logic       clear_fields;
    logic       count_digit;
    logic       clear_count;
    logic       line_done;
    logic [trace_char_pkg::DIGIT_COUNT_W-1:0] digit_count;

    trace_check_pkg::format_t     line_format;
    trace_check_pkg::time_field_t time_digits;
    trace_check_pkg::word_field_t pc_value;
    trace_check_pkg::word_field_t operand_value;

    line_parser_fsm u_parser (
        .clk           (clk),
        .reset         (reset),
        .char          (char),
        .digit_count   (digit_count),
        .nibble        (nibble),
        .shift_time    (shift_time),
        .shift_pc      (shift_pc),
        .shift_operand (shift_operand),
        .clear_fields  (clear_fields),
        .count_digit   (count_digit),
        .clear_count   (clear_count),
        .line_done     (line_done),
        .line_format   (line_format)
    );

    field_digit_counter u_counter (
        .clk         (clk),
        .reset       (reset),
        .clear_count (clear_count),
        .count_digit (count_digit),
        .digit_count (digit_count)
    );

    //////////////////////////////////////////////////
    // Field registers

    field_shift_reg #(.payload_t(trace_check_pkg::time_field_t)) u_time_reg (
        .clk          (clk),
        .reset        (reset),
        .clear_fields (clear_fields),
        .shift        (shift_time),
        .nibble       (nibble),
        .value        (time_digits)
    );

    field_shift_reg #(.payload_t(trace_check_pkg::word_field_t)) u_pc_reg (
        .clk          (clk),
        .reset        (reset),
        .clear_fields (clear_fields),
        .shift        (shift_pc),
        .nibble       (nibble),
        .value        (pc_value)
    );

    // Register number or address
    field_shift_reg #(.payload_t(trace_check_pkg::word_field_t)) u_operand_reg (
        .clk          (clk),
        .reset        (reset),
        .clear_fields (clear_fields),
        .shift        (shift_operand),
        .nibble       (nibble),
        .value        (operand_value)
    );

    field_rule_checker u_checker (
        .line_done     (line_done),
        .line_format   (line_format),
        .freq          (freq),
        .time_digits   (time_digits),
        .pc_value      (pc_value),
        .operand_value (operand_value),
        .format_type   (format_type),
        .error_code    (error_code)
    );

endmodule
